// ==== sim/regbus_golden.txt ====
# cmd arg1 arg2, hex. W addr data | T index data | F axis value | I id 0 | N cycles 0
# R addr expected_rdata | A expected_amp_enable expected_dac_cmd (axis4..axis1) | E test 0
I 5 0
R 0000 50000000
R 0011 00008000
R 0041 00008000
R 0010 00008000
R 0012 00000000
R 1011 00000000
R 0051 00000000
A 0 8000800080008000
E 1 0
W 0011 00001234
W 0021 ffff9000
W 0041 0000abcd
R 0011 00001234
R 0021 00009000
A 0 abcd800090001234
F 3 8077
N 1 0
R 0030 00008077
E 2 0
W 0000 000c0000
W 0000 00000f0f
A f abcd800090001234
R 0000 5004000f
W 0000 00000d00
A 2 abcd800090001234
W 0000 0000000f
A 2 abcd800090001234
W 0000 00080000
A 0 abcd800090001234
R 0000 50000000
E 3 0
T 0 abcd8200
T 1 00008300
T 2 00007f00
T 3 00008010
T 4 000c0f07
N 6 0
R 0011 00008200
R 0021 00008300
R 0031 00007f00
R 0041 00008010
R 0000 50040007
A 7 80107f0083008200
E 4 0
W 0000 000c0f0f
F 1 8600
N 3 0
F 1 8000
N 2 0
A f 80107f0083008200
F 1 8600
N 4 0
F 1 8000
N 2 0
A e 80107f0083008200
R 0000 5004010e
W 0000 00000101
A f 80107f0083008200
R 0000 5004000f
E 5 0

// ==== sources.f ====
source/mc_pkg.sv
source/rt_write_merge.sv
source/safety_check.sv
source/axis_channel.sv
source/board_regs.sv
source/reg_read_mux.sv
source/mc_regbus_top.sv
sim/regbus_checker.sv
sim/tb_mc_regbus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mc_regbus
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_mc_regbus.sv ====
`timescale 1ns/1ns

module tb_mc_regbus import mc_pkg::*; ();

    logic                      sysclk;
    logic                      arst_n;
    logic                      host_wen;
    logic [ADDR_W-1:0]         host_waddr;
    logic [DATA_W-1:0]         host_wdata;
    logic [ADDR_W-1:0]         raddr;
    logic [DATA_W-1:0]         rdata;
    logic                      rt_wen;
    logic [RT_ADDR_W-1:0]      rt_waddr;
    logic [DATA_W-1:0]         rt_wdata;
    logic [NUM_AXES*CMD_W-1:0] cur_fb;      // axis 1 in the low bits
    logic [3:0]                board_id;
    logic [NUM_AXES*CMD_W-1:0] dac_cmd;
    logic [NUM_AXES-1:0]       amp_enable;
    logic                      pwr_enable;

    // checker strobes and expected values
    logic                      chk_rd;
    logic                      chk_amp;
    logic                      test_end;
    logic                      run_done;
    logic [ADDR_W-1:0]         exp_addr;
    logic [DATA_W-1:0]         exp_rdata;
    logic [NUM_AXES-1:0]       exp_amp;
    logic [NUM_AXES*CMD_W-1:0] exp_dac;
    int                        test_id;
    int                        errors;
    int                        checks;

    // golden commands, one entry per file line
    byte         gcmd[$];
    logic [63:0] garg1[$];
    logic [63:0] garg2[$];
    int          bad_lines;
    int          cycle_cnt;
    int          cycle_limit;

    mc_regbus_top uut (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .host_wen   (host_wen),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .raddr      (raddr),
        .rdata      (rdata),
        .rt_wen     (rt_wen),
        .rt_waddr   (rt_waddr),
        .rt_wdata   (rt_wdata),
        .cur_fb     (cur_fb),
        .board_id   (board_id),
        .dac_cmd    (dac_cmd),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable)
    );

    regbus_checker u_chk (
        .sysclk     (sysclk),
        .rdata      (rdata),
        .amp_enable (amp_enable),
        .dac_cmd    (dac_cmd),
        .pwr_enable (pwr_enable),
        .chk_rd     (chk_rd),
        .exp_addr   (exp_addr),
        .exp_rdata  (exp_rdata),
        .chk_amp    (chk_amp),
        .exp_amp    (exp_amp),
        .exp_dac    (exp_dac),
        .test_end   (test_end),
        .test_id    (test_id),
        .run_done   (run_done),
        .errors     (errors),
        .checks     (checks)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns period
    end

    // --------------------
    // golden file
    task automatic load_golden();
        int          fd;
        int          n;
        int          r;
        string       line;
        logic [7:0]  c;
        logic [63:0] a;
        logic [63:0] b;
        fd = $fopen("sim/regbus_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/regbus_golden.txt, nothing was run");
            bad_lines = bad_lines + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (r != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%c %h %h", c, a, b);
                    if (n == 3) begin
                        gcmd.push_back(c);
                        garg1.push_back(a);
                        garg2.push_back(b);
                    end else begin
                        $display("golden file line not understood: %s", line);
                        bad_lines = bad_lines + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // clock cycles one command takes
    function automatic int command_cycles(byte c, logic [63:0] a);
        case (c)
            "W", "T", "A", "E": return 1;
            "R":                return 2;      // address cycle plus compare
            "N":                return int'(a[31:0]);
            default:            return 0;      // level changes only
        endcase
    endfunction

    // --------------------
    // stimulus, all entered 1 ns after a rising edge
    task automatic host_write(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
        host_wen   = 1'b1;
        host_waddr = addr;
        host_wdata = data;
        @(posedge sysclk);
        #1 host_wen = 1'b0;
    endtask

    task automatic rt_write(logic [RT_ADDR_W-1:0] idx, logic [DATA_W-1:0] data);
        rt_wen   = 1'b1;
        rt_waddr = idx;
        rt_wdata = data;
        @(posedge sysclk);
        #1 rt_wen = 1'b0;
    endtask

    task automatic read_check(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] expect_val);
        raddr = addr;
        @(posedge sysclk);
        #1;                               // rdata registered now
        chk_rd    = 1'b1;
        exp_addr  = addr;
        exp_rdata = expect_val;
        @(posedge sysclk);
        #1 chk_rd = 1'b0;
    endtask

    task automatic amp_check(logic [NUM_AXES-1:0] amp, logic [NUM_AXES*CMD_W-1:0] dac);
        chk_amp = 1'b1;
        exp_amp = amp;
        exp_dac = dac;
        @(posedge sysclk);
        #1 chk_amp = 1'b0;
    endtask

    task automatic finish_test(int id);
        test_end = 1'b1;
        test_id  = id;
        @(posedge sysclk);
        #1 test_end = 1'b0;
    endtask

    task automatic idle_cycles(int n);
        if (n > 0) begin
            repeat (n) @(posedge sysclk);
            #1;                           // back to the drive point
        end
    endtask

    task automatic set_feedback(int ax, logic [CMD_W-1:0] value);
        if (ax >= 1 && ax <= NUM_AXES) begin
            cur_fb[(ax - 1) * CMD_W +: CMD_W] = value;
        end else begin
            $display("golden file names axis %0d, which does not exist", ax);
            bad_lines = bad_lines + 1;
        end
    endtask

    task automatic run_golden();
        for (int i = 0; i < gcmd.size(); i++) begin
            case (gcmd[i])
                "W": host_write(garg1[i][ADDR_W-1:0], garg2[i][DATA_W-1:0]);
                "T": rt_write(garg1[i][RT_ADDR_W-1:0], garg2[i][DATA_W-1:0]);
                "F": set_feedback(int'(garg1[i][3:0]), garg2[i][CMD_W-1:0]);
                "I": board_id = garg1[i][3:0];
                "N": idle_cycles(int'(garg1[i][31:0]));
                "R": read_check(garg1[i][ADDR_W-1:0], garg2[i][DATA_W-1:0]);
                "A": amp_check(garg1[i][NUM_AXES-1:0], garg2[i]);
                "E": finish_test(int'(garg1[i][15:0]));
                default: begin
                    $display("golden file has unknown command %c", gcmd[i]);
                    bad_lines = bad_lines + 1;
                end
            endcase
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        arst_n      = 1'b0;
        host_wen    = 1'b0;
        host_waddr  = '0;
        host_wdata  = '0;
        raddr       = '0;
        rt_wen      = 1'b0;
        rt_waddr    = '0;
        rt_wdata    = '0;
        cur_fb      = {NUM_AXES{MIDSCALE}};   // zero current on every axis
        board_id    = 4'd0;
        chk_rd      = 1'b0;
        chk_amp     = 1'b0;
        test_end    = 1'b0;
        run_done    = 1'b0;
        exp_addr    = '0;
        exp_rdata   = '0;
        exp_amp     = '0;
        exp_dac     = '0;
        test_id     = 0;
        bad_lines   = 0;
        cycle_cnt   = 0;
        cycle_limit = 8 + 2 + 200;           // reset, wrap-up and slack
        load_golden();
        for (int i = 0; i < gcmd.size(); i++) begin
            cycle_limit = cycle_limit + command_cycles(gcmd[i], garg1[i]);
        end
        repeat (8) @(posedge sysclk);
        #1 arst_n = 1'b1;
        run_golden();
        run_done = 1'b1;                     // checker prints the counts
        @(posedge sysclk);
        #1 run_done = 1'b0;
        if (errors == 0 && bad_lines == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // hang guard
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

// ==== sim/regbus_checker.sv ====
`timescale 1ns/1ns

module regbus_checker import mc_pkg::*; (
    input  logic                      sysclk,
    input  logic [DATA_W-1:0]         rdata,
    input  logic [NUM_AXES-1:0]       amp_enable,
    input  logic [NUM_AXES*CMD_W-1:0] dac_cmd,
    input  logic                      pwr_enable,
    input  logic                      chk_rd,
    input  logic [ADDR_W-1:0]         exp_addr,
    input  logic [DATA_W-1:0]         exp_rdata,
    input  logic                      chk_amp,
    input  logic [NUM_AXES-1:0]       exp_amp,
    input  logic [NUM_AXES*CMD_W-1:0] exp_dac,
    input  logic                      test_end,
    input  int                        test_id,
    input  logic                      run_done,
    output int                        errors,
    output int                        checks
);

    int err_total   = 0;
    int chk_total   = 0;
    int test_errs   = 0;   // reset at each test end
    int test_checks = 0;
    int tests       = 0;
    int tests_bad   = 0;

    assign errors = err_total;
    assign checks = chk_total;

    // strobes change 1 ns after an edge, sampled on the next one
    always @(posedge sysclk) begin
        if (chk_rd) begin
            chk_total   = chk_total + 1;
            test_checks = test_checks + 1;
            if (rdata !== exp_rdata) begin
                $display("CHECK FAILED at %0t ns: read %h gave %h, expected %h",
                         $time, exp_addr, rdata, exp_rdata);
                err_total = err_total + 1;
                test_errs = test_errs + 1;
            end
            // status read also gives the expected power enable pin
            if (exp_addr[15:12] == ADDR_MAIN && exp_addr[7:4] == CHAN_BOARD
                    && exp_addr[3:0] == OFF_STATUS) begin
                chk_total   = chk_total + 1;
                test_checks = test_checks + 1;
                if (pwr_enable !== exp_rdata[ST_PWR_EN]) begin
                    $display("CHECK FAILED at %0t ns: pwr_enable %b, expected %b",
                             $time, pwr_enable, exp_rdata[ST_PWR_EN]);
                    err_total = err_total + 1;
                    test_errs = test_errs + 1;
                end
            end
        end
        if (chk_amp) begin
            chk_total   = chk_total + 1;
            test_checks = test_checks + 1;
            if (amp_enable !== exp_amp || dac_cmd !== exp_dac) begin
                $display("CHECK FAILED at %0t ns: amp_enable %h dac_cmd %h, expected %h %h",
                         $time, amp_enable, dac_cmd, exp_amp, exp_dac);
                err_total = err_total + 1;
                test_errs = test_errs + 1;
            end
        end
        // --------------------
        // per-test line
        if (test_end) begin
            tests = tests + 1;
            if (test_errs == 0) begin
                $display("test %0d: passed, %0d checks", test_id, test_checks);
            end else begin
                $display("test %0d: failed, %0d of %0d checks wrong",
                         test_id, test_errs, test_checks);
                tests_bad = tests_bad + 1;
            end
            test_errs   = 0;
            test_checks = 0;
        end
        if (run_done) begin
            $display("checks %0d, errors %0d, tests %0d, tests failed %0d",
                     chk_total, err_total, tests, tests_bad);
        end
    end

endmodule

// ==== source/mc_regbus_top.sv ====
`timescale 1ns/1ns

module mc_regbus_top import mc_pkg::*; (
    input  logic                      sysclk,
    input  logic                      arst_n,
    input  logic                      host_wen,
    input  logic [ADDR_W-1:0]         host_waddr,
    input  logic [DATA_W-1:0]         host_wdata,
    input  logic [ADDR_W-1:0]         raddr,
    output logic [DATA_W-1:0]         rdata,
    input  logic                      rt_wen,
    input  logic [RT_ADDR_W-1:0]      rt_waddr,
    input  logic [DATA_W-1:0]         rt_wdata,
    input  logic [NUM_AXES*CMD_W-1:0] cur_fb,      // axis 1 in the low bits
    input  logic [3:0]                board_id,
    output logic [NUM_AXES*CMD_W-1:0] dac_cmd,
    output logic [NUM_AXES-1:0]       amp_enable,
    output logic                      pwr_enable
);

    // shared write bus
    logic                       reg_wen;
    logic [ADDR_W-1:0]          reg_waddr;
    logic [DATA_W-1:0]          reg_wdata;

    logic [NUM_AXES-1:0]        clear_disable;   // board -> axes
    logic [NUM_AXES-1:0]        safety_disable;  // axes -> board
    logic [DATA_W-1:0]          status_word;
    logic [NUM_AXES*DATA_W-1:0] axis_words;      // one read word per axis

    // --------------------
    // write bus source
    rt_write_merge u_merge (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .host_wen   (host_wen),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .rt_wen     (rt_wen),
        .rt_waddr   (rt_waddr),
        .rt_wdata   (rt_wdata),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata)
    );

    // channel 0
    board_regs u_board (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_wen        (reg_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .clear_disable  (clear_disable),
        .amp_enable     (amp_enable),
        .pwr_enable     (pwr_enable),
        .status_word    (status_word)
    );

    // --------------------
    // axes on channels 1..4
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_channel #(.CHAN(i + 1)) u_axis (
            .sysclk        (sysclk),
            .arst_n        (arst_n),
            .reg_wen       (reg_wen),
            .reg_waddr     (reg_waddr),
            .reg_wdata     (reg_wdata),
            .cur_fb        (cur_fb[i*CMD_W +: CMD_W]),
            .clear_disable (clear_disable[i]),
            .raddr_off     (raddr[3:0]),
            .dac_cmd       (dac_cmd[i*CMD_W +: CMD_W]),
            .amp_disable   (safety_disable[i]),
            .rd_word       (axis_words[i*DATA_W +: DATA_W])
        );
    end

    // registered read path
    reg_read_mux u_rmux (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .raddr       (raddr),
        .status_word (status_word),
        .axis_words  (axis_words),
        .rdata       (rdata)
    );

endmodule

// ==== source/reg_read_mux.sv ====
`timescale 1ns/1ns

module reg_read_mux import mc_pkg::*; (
    input  logic                         sysclk,
    input  logic                         arst_n,
    input  logic [ADDR_W-1:0]            raddr,
    input  logic [DATA_W-1:0]            status_word,
    input  logic [NUM_AXES*DATA_W-1:0]   axis_words,
    output logic [DATA_W-1:0]            rdata
);

    logic [3:0]        rd_space;
    logic [3:0]        rd_chan;
    logic [3:0]        rd_off;
    logic [DATA_W-1:0] rd_sel;   // word picked this cycle

    assign rd_space = raddr[15:12];
    assign rd_chan  = raddr[7:4];
    assign rd_off   = raddr[3:0];

    // --------------------
    // decode
    always_comb begin
        if (rd_space != ADDR_MAIN) begin
            rd_sel = '0;                                  // other spaces dropped
        end else if (rd_chan == CHAN_BOARD) begin
            rd_sel = (rd_off == OFF_STATUS) ? status_word : '0;
        end else if (rd_chan <= 4'(NUM_AXES)) begin
            rd_sel = axis_words[(int'(rd_chan) - 1) * DATA_W +: DATA_W];
        end else begin
            rd_sel = '0;                                  // no such axis
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_sel;
        end
    end

    // any access outside the main space returns zero next cycle
    assert property (@(posedge sysclk) disable iff (!arst_n)
        (rd_space != ADDR_MAIN) |=> (rdata == '0))
        else $error("reg_read_mux: nonzero data from space %0h", $past(rd_space));

endmodule

// ==== source/board_regs.sv ====
`timescale 1ns/1ns

module board_regs import mc_pkg::*; (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                reg_wen,
    input  logic [ADDR_W-1:0]   reg_waddr,
    input  logic [DATA_W-1:0]   reg_wdata,
    input  logic [3:0]          board_id,
    input  logic [NUM_AXES-1:0] safety_disable,
    output logic [NUM_AXES-1:0] clear_disable,
    output logic [NUM_AXES-1:0] amp_enable,
    output logic                pwr_enable,
    output logic [DATA_W-1:0]   status_word
);

    logic                status_wr;  // write to channel 0 status
    logic [NUM_AXES-1:0] amp_mask;   // axes touched by this write
    logic [NUM_AXES-1:0] amp_val;
    logic                pwr_set;    // power mask with value 1
    logic [NUM_AXES-1:0] amp_en_q;   // requested amp enables

    assign status_wr = reg_wen
                    && (reg_waddr[15:12] == ADDR_MAIN)
                    && (reg_waddr[7:4] == CHAN_BOARD)
                    && (reg_waddr[3:0] == OFF_STATUS);

    assign amp_mask = reg_wdata[ST_AMP_MASK_LSB +: NUM_AXES];
    assign amp_val  = reg_wdata[ST_AMP_EN_LSB +: NUM_AXES];
    assign pwr_set  = reg_wdata[ST_PWR_MASK] & reg_wdata[ST_PWR_EN];

    // --------------------
    // masked enable writes
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_en_q   <= '0;
            pwr_enable <= 1'b0;
        end else if (status_wr) begin
            amp_en_q <= (amp_en_q & ~amp_mask) | (amp_val & amp_mask);
            if (reg_wdata[ST_PWR_MASK]) begin
                pwr_enable <= reg_wdata[ST_PWR_EN];
            end
        end
    end

    // clear pulse rides on the write cycle itself
    // so the latch drops on the same edge the enable sets
    assign clear_disable = {NUM_AXES{status_wr}}
                         & ((amp_mask & amp_val) | {NUM_AXES{pwr_set}});

    // effective enables, power and safety gate each axis
    assign amp_enable = amp_en_q & {NUM_AXES{pwr_enable}} & ~safety_disable;

    // --------------------
    // status readback
    always_comb begin
        status_word = '0;
        status_word[ST_AMP_EN_LSB +: NUM_AXES]   = amp_enable;
        status_word[ST_AMP_MASK_LSB +: NUM_AXES] = safety_disable;  // trip bits
        status_word[ST_PWR_EN]                   = pwr_enable;
        status_word[ST_BOARD_ID_LSB +: 4]        = board_id;
    end

endmodule

// ==== source/axis_channel.sv ====
`timescale 1ns/1ns

module axis_channel import mc_pkg::*; #(
    parameter int CHAN = 1               // axis channel, 1..4
) (
    input  logic              sysclk,
    input  logic              arst_n,
    input  logic              reg_wen,
    input  logic [ADDR_W-1:0] reg_waddr,
    input  logic [DATA_W-1:0] reg_wdata,
    input  logic [CMD_W-1:0]  cur_fb,
    input  logic              clear_disable,
    input  logic [3:0]        raddr_off,
    output logic [CMD_W-1:0]  dac_cmd,
    output logic              amp_disable,
    output logic [DATA_W-1:0] rd_word
);

    logic             dac_wr;  // dac write to this channel
    logic [CMD_W-1:0] fb_q;    // feedback sample

    assign dac_wr = reg_wen
                 && (reg_waddr[15:12] == ADDR_MAIN)
                 && (reg_waddr[7:4] == 4'(CHAN))
                 && (reg_waddr[3:0] == OFF_DAC_CTRL);

    // --------------------
    // current command
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_cmd <= MIDSCALE;              // zero current out of reset
        end else if (dac_wr) begin
            dac_cmd <= reg_wdata[CMD_W-1:0];
        end
    end

    // feedback taken every cycle
    always_ff @(posedge sysclk) begin
        fb_q <= cur_fb;
    end

    // readback by offset
    always_comb begin
        case (raddr_off)
            OFF_ADC_DATA: rd_word = {{(DATA_W - CMD_W){1'b0}}, fb_q};
            OFF_DAC_CTRL: rd_word = {{(DATA_W - CMD_W){1'b0}}, dac_cmd};
            default:      rd_word = '0;       // unused offsets
        endcase
    end

    // overcurrent watch on the sampled feedback
    safety_check u_safety (
        .sysclk        (sysclk),
        .arst_n        (arst_n),
        .cur_in        (fb_q),
        .cmd_in        (dac_cmd),
        .clear_disable (clear_disable),
        .amp_disable   (amp_disable)
    );

endmodule

// ==== source/safety_check.sv ====
`timescale 1ns/1ns

module safety_check import mc_pkg::*; (
    input  logic             sysclk,
    input  logic             arst_n,
    input  logic [CMD_W-1:0] cur_in,
    input  logic [CMD_W-1:0] cmd_in,
    input  logic             clear_disable,
    output logic             amp_disable
);

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);

    logic [CMD_W-1:0]        cur_mag;    // |feedback| around midscale
    logic [CMD_W-1:0]        cmd_mag;    // |command| around midscale
    logic [CMD_W+1:0]        cur_limit;  // 2*|cmd| + margin, room for the carry
    logic                    over;       // this sample is overcurrent
    logic [CNT_W-1:0]        over_cnt;   // run length so far
    logic [SAFETY_COUNT-1:0] over_hist;  // recent over samples, newest in bit 0

    // offset binary to magnitude
    assign cur_mag = (cur_in >= MIDSCALE) ? (cur_in - MIDSCALE) : (MIDSCALE - cur_in);
    assign cmd_mag = (cmd_in >= MIDSCALE) ? (cmd_in - MIDSCALE) : (MIDSCALE - cmd_in);

    assign cur_limit = {1'b0, cmd_mag, 1'b0} + (CMD_W + 2)'(SAFETY_MARGIN);
    assign over      = ((CMD_W + 2)'(cur_mag) > cur_limit);

    // --------------------
    // persistence count and latch
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            over_cnt    <= '0;             // re-enable restarts the run too
            amp_disable <= 1'b0;
        end else if (over) begin
            if (over_cnt == CNT_W'(SAFETY_COUNT - 1)) begin
                amp_disable <= 1'b1;       // held until cleared
            end else begin
                over_cnt <= over_cnt + 1'b1;
            end
        end else begin
            over_cnt <= '0;                // run broken
        end
    end

    // sample history for the latch check
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            over_hist <= '0;
        end else begin
            over_hist <= {over_hist[SAFETY_COUNT-2:0], over};
        end
    end

    // latch only rises at the end of a full overcurrent run
    assert property (@(posedge sysclk) disable iff (!arst_n)
        $rose(amp_disable) |-> (&over_hist))
        else $error("safety_check: disable without %0d overcurrent samples",
                    SAFETY_COUNT);

endmodule

// ==== source/rt_write_merge.sv ====
`timescale 1ns/1ns

module rt_write_merge import mc_pkg::*; (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic                 host_wen,
    input  logic [ADDR_W-1:0]    host_waddr,
    input  logic [DATA_W-1:0]    host_wdata,
    input  logic                 rt_wen,
    input  logic [RT_ADDR_W-1:0] rt_waddr,
    input  logic [DATA_W-1:0]    rt_wdata,
    output logic                 reg_wen,
    output logic [ADDR_W-1:0]    reg_waddr,
    output logic [DATA_W-1:0]    reg_wdata
);

    logic [DATA_W-1:0]    rt_buf [RT_LEN];  // block quadlets as received
    logic                 busy;             // replay owns the write bus
    logic [RT_ADDR_W-1:0] rt_cnt;           // quadlet on the bus now
    logic                 rt_last;          // status quadlet, end of replay
    logic [3:0]           rp_chan;          // axis channel of quadlets 0..3

    // --------------------
    // block buffer
    always_ff @(posedge sysclk) begin
        if (rt_wen && (rt_waddr < RT_ADDR_W'(RT_LEN))) begin
            rt_buf[rt_waddr] <= rt_wdata;
        end
    end

    // --------------------
    // replay sequencer
    assign rt_last = (rt_cnt == RT_ADDR_W'(RT_LEN - 1));

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            rt_cnt <= '0;
        end else if (rt_wen && (rt_waddr == RT_ADDR_W'(RT_LEN - 1))) begin
            busy   <= 1'b1;              // status quadlet arrived, start replay
            rt_cnt <= '0;
        end else if (busy) begin
            busy   <= !rt_last;          // drop after the status write
            rt_cnt <= rt_last ? '0 : rt_cnt + 1'b1;
        end
    end

    assign rp_chan = 4'(rt_cnt) + 4'd1;  // quadlet 0 -> axis 1

    // --------------------
    // bus merge, replay wins
    always_comb begin
        if (busy) begin
            reg_wen = 1'b1;
            if (rt_last) begin
                reg_waddr = {ADDR_MAIN, 4'd0, CHAN_BOARD, OFF_STATUS};
                reg_wdata = rt_buf[rt_cnt];            // full status word
            end else begin
                reg_waddr = {ADDR_MAIN, 4'd0, rp_chan, OFF_DAC_CTRL};
                reg_wdata = {{(DATA_W - CMD_W){1'b0}}, rt_buf[rt_cnt][CMD_W-1:0]};
            end
        end else begin
            reg_wen   = host_wen;
            reg_waddr = host_waddr;
            reg_wdata = host_wdata;
        end
    end

    // block index stays inside the five quadlets
    assert property (@(posedge sysclk) disable iff (!arst_n)
        rt_wen |-> (rt_waddr < RT_ADDR_W'(RT_LEN)))
        else $error("rt_write_merge: block address %0d out of range", rt_waddr);

    // a host write during replay never reaches the registers
    assert property (@(posedge sysclk) disable iff (!arst_n)
        busy |-> !host_wen)
        else $error("rt_write_merge: host write lost during replay");

endmodule

// ==== source/mc_pkg.sv ====
package mc_pkg;

    // --------------------
    // bus and axis sizes
    localparam int NUM_AXES  = 4;
    localparam int ADDR_W    = 16;   // register address
    localparam int DATA_W    = 32;   // one quadlet
    localparam int CMD_W     = 16;   // dac command and current feedback
    localparam int RT_ADDR_W = 3;    // real-time block index
    localparam int RT_LEN    = 5;    // four dac quadlets then the status word

    // --------------------
    // address fields
    // addr[15:12] space, addr[7:4] channel, addr[3:0] offset
    localparam logic [3:0] ADDR_MAIN  = 4'h0;  // the only space with registers
    localparam logic [3:0] CHAN_BOARD = 4'd0;  // axes sit on channels 1..4

    // offsets inside a channel
    localparam logic [3:0] OFF_STATUS   = 4'd0;  // board channel only
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;  // feedback readback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;  // current command

    // --------------------
    // current loop values, offset binary
    localparam logic [CMD_W-1:0] MIDSCALE = 16'h8000;  // zero current

    // safety trip
    localparam int               SAFETY_COUNT  = 4;       // consecutive samples
    localparam logic [CMD_W-1:0] SAFETY_MARGIN = 16'd256; // slack over 2*|cmd|

    // --------------------
    // status word layout
    localparam int ST_AMP_EN_LSB   = 0;   // amp enable values
    localparam int ST_AMP_MASK_LSB = 8;   // write mask, safety disables on read
    localparam int ST_PWR_EN       = 18;  // power enable value
    localparam int ST_PWR_MASK     = 19;  // power write mask
    localparam int ST_BOARD_ID_LSB = 28;  // rotary switch id

endpackage
